//--- logic/memAccessPkg.sv
package memAccessPkg;

    localparam int AddrWidth  = 32;
    localparam int DataWidth  = 32;
    localparam int OffsetBits = 2;
    localparam int ByteLanes  = DataWidth / 8;

    localparam logic [ByteLanes-1:0] AllLanes = '1;  // loads and full-word stores

    typedef enum logic [2:0] {
        loadByte,
        loadHalf,
        loadWord,
        loadByteU,
        loadHalfU,
        storeByte,
        storeHalf,
        storeWord
    } memOpT;

    function automatic logic isStore(input memOpT op);
        return op inside {storeByte, storeHalf, storeWord};
    endfunction

    // overlay the enabled byte lanes of newWord onto oldWord
    function automatic logic [DataWidth-1:0] mergeLanes(input logic [DataWidth-1:0] oldWord,
                                                        input logic [DataWidth-1:0] newWord,
                                                        input logic [ByteLanes-1:0] byteEn);
        logic [DataWidth-1:0] merged;
        merged = oldWord;
        for (int i = 0; i < ByteLanes; i++) begin
            if (byteEn[i]) begin
                merged[8*i +: 8] = newWord[8*i +: 8];
            end
        end
        return merged;
    endfunction

endpackage

//--- logic/storeAlign.sv
module storeAlign (
    input  logic                                 reqValid,
    input  memAccessPkg::memOpT                  reqOp,
    input  logic [memAccessPkg::AddrWidth-1:0]   reqAddr,
    input  logic [memAccessPkg::DataWidth-1:0]   reqWriteData,
    output logic                                 alignValid,
    output memAccessPkg::memOpT                  alignOp,
    output logic [memAccessPkg::AddrWidth-1:0]   alignAddr,
    output logic [memAccessPkg::DataWidth-1:0]   alignWriteData,
    output logic [memAccessPkg::ByteLanes-1:0]   alignByteEn,
    output logic                                 alignMisaligned
);
    import memAccessPkg::*;

    logic [OffsetBits-1:0] offset;
    logic [ByteLanes-1:0]  storeMask;

    assign offset = reqAddr[OffsetBits-1:0];

    always_comb begin
        alignMisaligned = 1'b0;
        alignWriteData  = reqWriteData;
        storeMask       = AllLanes;
        case (reqOp)
            loadHalf, loadHalfU: begin
                alignMisaligned = offset[0];
            end
            loadWord, storeWord: begin
                alignMisaligned = |offset;
            end
            storeByte: begin
                alignWriteData = {ByteLanes{reqWriteData[7:0]}};  // byte copied to every lane
                storeMask      = ByteLanes'(1) << offset;
            end
            storeHalf: begin
                alignMisaligned = offset[0];
                alignWriteData  = {2{reqWriteData[15:0]}};
                storeMask       = offset[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                alignMisaligned = 1'b0;  // byte loads are always aligned
            end
        endcase
    end

    assign alignByteEn = isStore(reqOp) ? storeMask : AllLanes;

    assign alignValid = reqValid;
    assign alignOp    = reqOp;
    assign alignAddr  = reqAddr;

endmodule

//--- logic/dataCache.sv
module dataCache #(
    parameter int IndexBits = 4
) (
    input  logic                                                     clk,
    input  logic                                                     rstN,
    input  logic                                                     alignValid,
    input  memAccessPkg::memOpT                                      alignOp,
    input  logic [memAccessPkg::AddrWidth-1:0]                       alignAddr,
    input  logic [memAccessPkg::DataWidth-1:0]                       alignWriteData,
    input  logic [memAccessPkg::ByteLanes-1:0]                       alignByteEn,
    input  logic                                                     alignMisaligned,
    output logic                                                     memReq,
    output logic                                                     memWrite,
    output logic [memAccessPkg::AddrWidth-memAccessPkg::OffsetBits-1:0] memWordAddr,
    output logic [memAccessPkg::DataWidth-1:0]                       memWriteData,
    output logic [memAccessPkg::ByteLanes-1:0]                       memByteEn,
    input  logic                                                     memDone,
    input  logic [memAccessPkg::DataWidth-1:0]                       memReadData,
    output logic                                                     wordValid,
    output logic [memAccessPkg::DataWidth-1:0]                       wordData,
    output memAccessPkg::memOpT                                      wordOp,
    output logic [memAccessPkg::OffsetBits-1:0]                      wordOffset,
    output logic                                                     wordError
);
    import memAccessPkg::*;

    localparam int Lines   = 1 << IndexBits;
    localparam int TagBits = AddrWidth - IndexBits - OffsetBits;

    typedef enum logic [1:0] {idle, lookup, waitMem, respond} stateT;

    stateT                state;
    logic [Lines-1:0]     validBits;
    logic [TagBits-1:0]   tagArray [Lines];
    logic [DataWidth-1:0] dataArray [Lines];

    logic [IndexBits-1:0] inIndex;
    logic [TagBits-1:0]   inTag;
    logic                 inHit;

    memOpT                opReg;
    logic [AddrWidth-1:0] addrReg;
    logic [DataWidth-1:0] dataReg;
    logic [ByteLanes-1:0] byteEnReg;
    logic                 misReg;
    logic                 hitReg;
    logic [DataWidth-1:0] lineWord;  // cached word on lookup, fill word after memDone

    logic [IndexBits-1:0] regIndex;
    logic [TagBits-1:0]   regTag;
    logic                 storeReg;
    logic                 fastDone;
    logic                 fillDone;

    assign inIndex = alignAddr[OffsetBits +: IndexBits];
    assign inTag   = alignAddr[AddrWidth-1 -: TagBits];
    assign inHit   = validBits[inIndex] && (tagArray[inIndex] == inTag);

    assign regIndex = addrReg[OffsetBits +: IndexBits];
    assign regTag   = addrReg[AddrWidth-1 -: TagBits];
    assign storeReg = isStore(opReg);
    assign fastDone = misReg || (!storeReg && hitReg);  // no trip to memory
    assign fillDone = (state == waitMem) && memDone && !storeReg;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= idle;
        end else begin
            case (state)
                idle:    if (alignValid) state <= lookup;
                lookup:  state <= fastDone ? idle : waitMem;
                waitMem: if (memDone) state <= respond;
                respond: state <= idle;
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && alignValid) begin
            opReg     <= alignOp;
            addrReg   <= alignAddr;
            dataReg   <= alignWriteData;
            byteEnReg <= alignByteEn;
            misReg    <= alignMisaligned;
            hitReg    <= inHit;
            lineWord  <= dataArray[inIndex];
        end else if (state == waitMem && memDone) begin
            lineWord <= memReadData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validBits <= '0;
        end else if (fillDone) begin
            validBits[regIndex] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == lookup && storeReg && hitReg && !misReg) begin
            dataArray[regIndex] <= mergeLanes(lineWord, dataReg, byteEnReg);  // write-through hit
        end else if (fillDone) begin
            tagArray[regIndex]  <= regTag;
            dataArray[regIndex] <= memReadData;
        end
    end

    assign memReq       = (state == lookup) && !fastDone;
    assign memWrite     = storeReg;
    assign memWordAddr  = addrReg[AddrWidth-1:OffsetBits];
    assign memWriteData = dataReg;
    assign memByteEn    = byteEnReg;

    assign wordValid  = ((state == lookup) && fastDone) || (state == respond);
    assign wordData   = lineWord;
    assign wordOp     = opReg;
    assign wordOffset = addrReg[OffsetBits-1:0];
    assign wordError  = misReg;

endmodule

//--- logic/backingMemory.sv
module backingMemory #(
    parameter int MemWords   = 1024,
    parameter int MemLatency = 3
) (
    input  logic                                                     clk,
    input  logic                                                     rstN,
    input  logic                                                     memReq,
    input  logic                                                     memWrite,
    input  logic [memAccessPkg::AddrWidth-memAccessPkg::OffsetBits-1:0] memWordAddr,
    input  logic [memAccessPkg::DataWidth-1:0]                       memWriteData,
    input  logic [memAccessPkg::ByteLanes-1:0]                       memByteEn,
    output logic                                                     memDone,
    output logic [memAccessPkg::DataWidth-1:0]                       memReadData
);
    import memAccessPkg::*;

    localparam int WordIdxBits = $clog2(MemWords);
    localparam int CountBits   = $clog2(MemLatency + 1);

    logic [DataWidth-1:0]   mem [MemWords];
    logic [WordIdxBits-1:0] wordIdx;
    logic [CountBits-1:0]   count;

    assign wordIdx = memWordAddr[WordIdxBits-1:0];  // wraps at MemWords

    always_ff @(posedge clk) begin
        if (memReq) begin
            memReadData <= mem[wordIdx];
            if (memWrite) begin
                mem[wordIdx] <= mergeLanes(mem[wordIdx], memWriteData, memByteEn);
            end
        end
    end

    // done when the count reaches one, MemLatency cycles after memReq
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            count <= '0;
        end else if (memReq) begin
            count <= CountBits'(MemLatency);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign memDone = (count == CountBits'(1));

endmodule

//--- logic/loadExtract.sv
module loadExtract (
    input  logic                                 clk,
    input  logic                                 rstN,
    input  logic                                 wordValid,
    input  logic [memAccessPkg::DataWidth-1:0]   wordData,
    input  memAccessPkg::memOpT                  wordOp,
    input  logic [memAccessPkg::OffsetBits-1:0]  wordOffset,
    input  logic                                 wordError,
    output logic                                 respValid,
    output logic [memAccessPkg::DataWidth-1:0]   respData,
    output logic                                 respError
);
    import memAccessPkg::*;

    logic [7:0]           selByte;
    logic [15:0]          selHalf;
    logic [DataWidth-1:0] extData;

    assign selByte = wordData[{wordOffset, 3'b000} +: 8];
    assign selHalf = wordData[{wordOffset[1], 4'b0000} +: 16];  // offset already checked even

    always_comb begin
        case (wordOp)
            loadByte:  extData = {{(DataWidth-8){selByte[7]}}, selByte};
            loadByteU: extData = {{(DataWidth-8){1'b0}}, selByte};
            loadHalf:  extData = {{(DataWidth-16){selHalf[15]}}, selHalf};
            loadHalfU: extData = {{(DataWidth-16){1'b0}}, selHalf};
            loadWord:  extData = wordData;
            default:   extData = '0;  // stores
        endcase
        if (wordError) begin
            extData = '0;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            respValid <= 1'b0;
            respError <= 1'b0;
        end else begin
            respValid <= wordValid;
            respError <= wordValid && wordError;
        end
    end

    always_ff @(posedge clk) begin
        if (wordValid) begin
            respData <= extData;
        end
    end

endmodule

//--- logic/dataMemoryController.sv
module dataMemoryController #(
    parameter int IndexBits  = 4,
    parameter int MemLatency = 3,
    parameter int MemWords   = 1024
) (
    input  logic                                 clk,
    input  logic                                 rstN,
    input  logic                                 reqValid,
    input  memAccessPkg::memOpT                  reqOp,
    input  logic [memAccessPkg::AddrWidth-1:0]   reqAddr,
    input  logic [memAccessPkg::DataWidth-1:0]   reqWriteData,
    output logic                                 respValid,
    output logic [memAccessPkg::DataWidth-1:0]   respData,
    output logic                                 respError
);
    import memAccessPkg::*;

    logic                           alignValid;
    memOpT                          alignOp;
    logic [AddrWidth-1:0]           alignAddr;
    logic [DataWidth-1:0]           alignWriteData;
    logic [ByteLanes-1:0]           alignByteEn;
    logic                           alignMisaligned;

    logic                           memReq;
    logic                           memWrite;
    logic [AddrWidth-OffsetBits-1:0] memWordAddr;
    logic [DataWidth-1:0]           memWriteData;
    logic [ByteLanes-1:0]           memByteEn;
    logic                           memDone;
    logic [DataWidth-1:0]           memReadData;

    logic                           wordValid;
    logic [DataWidth-1:0]           wordData;
    memOpT                          wordOp;
    logic [OffsetBits-1:0]          wordOffset;
    logic                           wordError;

    storeAlign align0 (
        .reqValid(reqValid), .reqOp(reqOp), .reqAddr(reqAddr), .reqWriteData(reqWriteData),
        .alignValid(alignValid), .alignOp(alignOp), .alignAddr(alignAddr),
        .alignWriteData(alignWriteData), .alignByteEn(alignByteEn),
        .alignMisaligned(alignMisaligned)
    );

    dataCache #(.IndexBits(IndexBits)) cache0 (
        .clk(clk), .rstN(rstN),
        .alignValid(alignValid), .alignOp(alignOp), .alignAddr(alignAddr),
        .alignWriteData(alignWriteData), .alignByteEn(alignByteEn),
        .alignMisaligned(alignMisaligned),
        .memReq(memReq), .memWrite(memWrite), .memWordAddr(memWordAddr),
        .memWriteData(memWriteData), .memByteEn(memByteEn),
        .memDone(memDone), .memReadData(memReadData),
        .wordValid(wordValid), .wordData(wordData), .wordOp(wordOp),
        .wordOffset(wordOffset), .wordError(wordError)
    );

    backingMemory #(.MemWords(MemWords), .MemLatency(MemLatency)) mem0 (
        .clk(clk), .rstN(rstN),
        .memReq(memReq), .memWrite(memWrite), .memWordAddr(memWordAddr),
        .memWriteData(memWriteData), .memByteEn(memByteEn),
        .memDone(memDone), .memReadData(memReadData)
    );

    loadExtract extract0 (
        .clk(clk), .rstN(rstN),
        .wordValid(wordValid), .wordData(wordData), .wordOp(wordOp),
        .wordOffset(wordOffset), .wordError(wordError),
        .respValid(respValid), .respData(respData), .respError(respError)
    );

endmodule

//--- tb/dataMemoryController_checker.sv
module dataMemoryControllerChecker (
    input logic clk,
    input logic rstN,
    input logic reqValid,
    input logic respValid,
    input logic respError
);
    logic pending;  // request seen, response not yet

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pending <= 1'b0;
        end else if (reqValid) begin
            pending <= 1'b1;
        end else if (respValid) begin
            pending <= 1'b0;
        end
    end

    respQuietInReset: assert property (@(posedge clk) !rstN |-> !respValid)
        else $error("respValid high while reset is asserted");

    respSingleCycle: assert property (@(posedge clk) disable iff (!rstN)
        respValid |=> !respValid)
        else $error("respValid high on two cycles in a row");

    oneOutstanding: assert property (@(posedge clk) disable iff (!rstN)
        reqValid |-> (!pending || respValid))
        else $error("new request issued before the previous response");

    errorOnlyWithResp: assert property (@(posedge clk) disable iff (!rstN)
        respError |-> respValid)
        else $error("respError high without respValid");

endmodule

bind dataMemoryController dataMemoryControllerChecker chk0 (
    .clk(clk), .rstN(rstN), .reqValid(reqValid), .respValid(respValid), .respError(respError)
);

//--- tb/dataMemoryControllerTb.sv
module dataMemoryControllerTb;
    import memAccessPkg::*;

    localparam int IndexBits    = 4;
    localparam int MemLatency   = 3;
    localparam int MemWords     = 1024;
    localparam int TagBits      = AddrWidth - IndexBits - OffsetBits;
    localparam int RefBytes     = 4 * MemWords;
    localparam int MissCycles   = MemLatency + 3;
    localparam int RequestCount = 299;  // directed requests, init stores and random ops
    localparam int CycleLimit   = (RequestCount + 20) * MissCycles;

    logic                 clk;
    logic                 rstN;
    logic                 reqValid;
    memOpT                reqOp;
    logic [AddrWidth-1:0] reqAddr;
    logic [DataWidth-1:0] reqWriteData;
    logic                 respValid;
    logic [DataWidth-1:0] respData;
    logic                 respError;

    logic [7:0]                refMem [RefBytes];
    logic [TagBits-1:0]        refTag [1 << IndexBits];
    logic [(1<<IndexBits)-1:0] refValid;
    int dataErrors;
    int flagErrors;
    int latencyErrors;
    int noRespErrors;
    int cycleCount;
    int seed = 32624;

    dataMemoryController #(.IndexBits(IndexBits), .MemLatency(MemLatency),
                           .MemWords(MemWords)) dut0 (
        .clk(clk), .rstN(rstN), .reqValid(reqValid), .reqOp(reqOp), .reqAddr(reqAddr),
        .reqWriteData(reqWriteData), .respValid(respValid), .respData(respData),
        .respError(respError)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= CycleLimit) begin
            $display("timeout: run still going after %0d cycles", CycleLimit);
            $display("Some tests failed");
            $finish;
        end
    end

    function automatic logic [DataWidth-1:0] expectLoad(input memOpT op, input logic [31:0] addr);
        int base;
        logic [31:0] w;
        logic [7:0] b;
        logic [15:0] h;
        base = int'(addr % RefBytes) & ~3;
        w = {refMem[base+3], refMem[base+2], refMem[base+1], refMem[base]};
        b = w[8*addr[1:0] +: 8];
        h = w[16*addr[1] +: 16];
        case (op)
            loadByte:  return {{24{b[7]}}, b};
            loadByteU: return {24'h0, b};
            loadHalf:  return {{16{h[15]}}, h};
            loadHalfU: return {16'h0, h};
            loadWord:  return w;
            default:   return '0;
        endcase
    endfunction

    function automatic logic misaligned(input memOpT op, input logic [31:0] addr);
        case (op)
            loadHalf, loadHalfU, storeHalf: return addr[0];
            loadWord, storeWord:            return addr[1:0] != 2'b00;
            default:                        return 1'b0;
        endcase
    endfunction

    task automatic compareData(input string name, input logic [DataWidth-1:0] expected,
                               input logic [DataWidth-1:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s respData expected %h actual %h", name, expected, actual);
            dataErrors++;
        end
    endtask

    task automatic compareError(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("MISMATCH %s respError expected %b actual %b", name, expected, actual);
            flagErrors++;
        end
    endtask

    task automatic compareLatency(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("MISMATCH %s latency expected %0d actual %0d", name, expected, actual);
            latencyErrors++;
        end
    endtask

    // one request, wait for its response, check it, then update the model
    task automatic access(input string name, input memOpT op, input logic [31:0] addr,
                          input logic [31:0] wdata);
        logic bad;
        logic hit;
        int idx;
        int waited;
        int base;
        int nBytes;
        bad = misaligned(op, addr);
        idx = int'(addr[OffsetBits +: IndexBits]);
        hit = refValid[idx] && (refTag[idx] == addr[31 -: TagBits]);
        reqValid = 1'b1;
        reqOp = op;
        reqAddr = addr;
        reqWriteData = wdata;
        waited = 0;
        do begin
            @(posedge clk);
            #1;
            reqValid = 1'b0;
            waited++;
        end while (!respValid && waited < 4 * MissCycles);
        if (!respValid) begin
            $display("no response to %s after %0d cycles", name, waited);
            noRespErrors++;
        end else begin
            compareData(name, (bad || isStore(op)) ? '0 : expectLoad(op, addr), respData);
            compareError(name, bad, respError);
            compareLatency(name, (bad || (hit && !isStore(op))) ? 2 : MissCycles, waited);
        end
        base = int'(addr % RefBytes);
        nBytes = (op == storeByte) ? 1 : (op == storeHalf) ? 2 : 4;
        if (!bad && isStore(op)) begin
            for (int i = 0; i < nBytes; i++) begin
                refMem[base+i] = wdata[8*i +: 8];
            end
        end else if (!bad && !hit) begin
            refValid[idx] = 1'b1;  // load miss fills the line
            refTag[idx] = addr[31 -: TagBits];
        end
    endtask

    task automatic storeThenLoad();
        access("storeWord", storeWord, 32'h40, 32'hCAFE_F00D);
        access("firstLoad", loadWord, 32'h40, 32'h0);
        access("secondLoad", loadWord, 32'h40, 32'h0);
    endtask

    task automatic subWordLoads();
        access("patternStore", storeWord, 32'h80, 32'h9AF1_83C7);  // every byte negative
        for (int off = 0; off < 4; off++) begin
            access($sformatf("loadByte+%0d", off), loadByte, 32'h80 + off, 32'h0);
            access($sformatf("loadByteU+%0d", off), loadByteU, 32'h80 + off, 32'h0);
        end
        for (int off = 0; off < 4; off += 2) begin
            access($sformatf("loadHalf+%0d", off), loadHalf, 32'h80 + off, 32'h0);
            access($sformatf("loadHalfU+%0d", off), loadHalfU, 32'h80 + off, 32'h0);
        end
    endtask

    task automatic subWordStores();
        access("cachedByte", storeByte, 32'h81, 32'h0000_005A);
        access("cachedHalf", storeHalf, 32'h82, 32'h0000_1234);
        access("cachedReload", loadWord, 32'h80, 32'h0);
        access("uncachedInit", storeWord, 32'hC0, 32'h7654_3210);
        access("uncachedByte", storeByte, 32'hC3, 32'h0000_00A5);
        access("uncachedHalf", storeHalf, 32'hC0, 32'h0000_BEEF);
        access("uncachedReload", loadWord, 32'hC0, 32'h0);
    endtask

    task automatic indexConflict();
        access("conflictStoreA", storeWord, 32'h100, 32'h1111_AAAA);
        access("conflictStoreB", storeWord, 32'h140, 32'h2222_BBBB);
        for (int i = 0; i < 2; i++) begin
            access("conflictLoadA", loadWord, 32'h100, 32'h0);
            access("conflictLoadB", loadWord, 32'h140, 32'h0);
        end
    endtask

    task automatic misalignedAccess();
        access("misInit", storeWord, 32'h200, 32'h1111_2222);
        access("misLoadHalf", loadHalf, 32'h201, 32'h0);
        access("misLoadWord", loadWord, 32'h202, 32'h0);
        access("misStoreHalf", storeHalf, 32'h203, 32'h0000_FFFF);
        access("misStoreWord", storeWord, 32'h201, 32'hFFFF_FFFF);
        access("misReload", loadWord, 32'h200, 32'h0);
    endtask

    task automatic randomSequence();
        logic [31:0] r;
        logic [31:0] addr;
        memOpT op;
        for (int w = 0; w < 64; w++) begin
            access("randomInit", storeWord, 32'(4 * w), $random(seed));
        end
        for (int n = 0; n < 200; n++) begin
            r = $random(seed);
            op = memOpT'(r[2:0]);
            addr = {24'h0, r[15:8]};
            if (op inside {loadHalf, loadHalfU, storeHalf}) begin
                addr[0] = 1'b0;
            end
            if (op inside {loadWord, storeWord}) begin
                addr[1:0] = 2'b00;
            end
            access($sformatf("random%0d", n), op, addr, $random(seed));
        end
    endtask

    initial begin
        rstN = 1'b0;
        reqValid = 1'b0;
        reqOp = loadWord;
        reqAddr = '0;
        reqWriteData = '0;
        refValid = '0;
        repeat (2) @(posedge clk);
        #1 rstN = 1'b1;
        storeThenLoad();
        subWordLoads();
        subWordStores();
        indexConflict();
        misalignedAccess();
        randomSequence();
        $display("errors: data %0d, flag %0d, latency %0d, no response %0d",
                 dataErrors, flagErrors, latencyErrors, noRespErrors);
        if (dataErrors + flagErrors + latencyErrors + noRespErrors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- files.f
logic/memAccessPkg.sv
logic/storeAlign.sv
logic/dataCache.sv
logic/backingMemory.sv
logic/loadExtract.sv
logic/dataMemoryController.sv
tb/dataMemoryController_checker.sv
tb/dataMemoryControllerTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= dataMemoryControllerTb
FILELIST  ?= files.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
